// ==== project.f ====
rt_pkg.sv
stage_reg.sv
scene_buffer.sv
ray_intersector.sv
ray_shader.sv
ray_tracer.sv
rt_checker.sv
tb_ray_tracer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ray tracer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f project.f --top-module tb_ray_tracer -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== tb_ray_tracer.sv ====
`timescale 1ns/1ns

module tb_ray_tracer;
  import rt_pkg::*;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic [7:0] awaddr = '0;
  logic awvalid = 1'b0;
  logic [31:0] wdata = '0;
  logic wvalid = 1'b0;
  logic bready = 1'b1;
  logic [7:0] araddr = '0;
  logic arvalid = 1'b0;
  logic rready = 1'b1;
  logic ray_valid = 1'b0;
  ray_req_t ray = '0;
  logic pix_ready = 1'b1;
  logic awready, wready, bvalid, arready, rvalid, ray_ready, pix_valid;
  logic [1:0] bresp, rresp;
  logic [31:0] rdata;
  pixel_t pix;

  // testbench copy of the scene
  sphere_t sc [SCENE_DEPTH];
  int sc_count = 0;
  int rays_sent = 0;
  int cycles = 0;
  logic bp_on = 1'b0;

  always #2 clk = ~clk;

  ray_tracer dut0 (.*);

  rt_checker checker0 (
    .clk(clk), .rst_n(rst_n), .pix_valid(pix_valid), .pix_ready(pix_ready), .pix(pix),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  // random back-pressure on the pixel output
  always @(posedge clk) begin
    pix_ready <= bp_on ? 1'($urandom % 2) : 1'b1;
  end

  // limit grows with every ray handed to the dut
  always @(posedge clk) begin
    cycles++;
    if (cycles > 200 * rays_sent + 2000) begin
      $display("timeout after %0d cycles with %0d rays sent", cycles, rays_sent);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom % 32'(hi - lo + 1));
  endfunction

  // nearest hit over the scene copy followed by shading
  function automatic pixel_t ref_pixel(input ray_req_t r);
    longint ocx, ocy, ocz, dx, dy, dz, dt, ocsq, dsq, rad, best_dot;
    logic best_any;
    rgb_t best_col;
    pixel_t p;
    best_any = 1'b0;
    best_dot = 0;
    best_col = '0;
    dx = longint'(r.dir.x);
    dy = longint'(r.dir.y);
    dz = longint'(r.dir.z);
    dsq = dx * dx + dy * dy + dz * dz;
    for (int k = 0; k < sc_count; k++) begin
      ocx = longint'(sc[k].center.x) - longint'(r.origin.x);
      ocy = longint'(sc[k].center.y) - longint'(r.origin.y);
      ocz = longint'(sc[k].center.z) - longint'(r.origin.z);
      dt = ocx * dx + ocy * dy + ocz * dz;
      ocsq = ocx * ocx + ocy * ocy + ocz * ocz;
      rad = longint'(sc[k].radius);
      if (dt > 0 && ocsq * dsq - dt * dt <= rad * rad * dsq) begin
        // only a strictly nearer hit replaces the best so lower index keeps a tie
        if (!best_any || dt < best_dot) begin
          best_any = 1'b1;
          best_dot = dt;
          best_col = sc[k].color;
        end
      end
    end
    p.pixel_h = r.pixel_h;
    p.pixel_v = r.pixel_v;
    if (!best_any) p.color = BG_COLOR;
    else if (best_dot < FAR_DOT) p.color = best_col;
    else p.color = '{r: best_col.r >> 1, g: best_col.g >> 1, b: best_col.b >> 1};
    return p;
  endfunction

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    awaddr <= addr;
    wdata <= data;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    do @(posedge clk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    do @(posedge clk); while (!bvalid);
  endtask

  task automatic axi_read(input logic [7:0] addr, input logic [31:0] expected);
    checker0.expect_read(expected);
    @(posedge clk);
    araddr <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
  endtask

  function automatic logic [31:0] sphere_word(input sphere_t s, input int w);
    case (w)
      0: return {6'd0, s.center.y, 6'd0, s.center.x};
      1: return {8'd0, s.radius, 6'd0, s.center.z};
      default: return {8'd0, s.color.b, s.color.g, s.color.r};
    endcase
  endfunction

  task automatic load_sphere(input int k, input sphere_t s);
    for (int w = 0; w < 3; w++) axi_write(8'(k * OBJ_STRIDE + 4 * w), sphere_word(s, w));
    sc[k] = s;
  endtask

  task automatic set_count(input int n);
    axi_write(COUNT_ADDR, 32'(n));
    sc_count = (n > SCENE_DEPTH) ? SCENE_DEPTH : n;
  endtask

  task automatic send_ray(input ray_req_t r);
    checker0.expect_pixel(ref_pixel(r));
    rays_sent++;
    @(posedge clk);
    ray <= r;
    ray_valid <= 1'b1;
    do @(posedge clk); while (!ray_ready);
    ray_valid <= 1'b0;
  endtask

  function automatic ray_req_t make_ray(input int ox, input int oy, input int oz,
                                        input int dx, input int dy, input int dz);
    ray_req_t r;
    r.origin = '{x: coord_t'(ox), y: coord_t'(oy), z: coord_t'(oz)};
    r.dir = '{x: coord_t'(dx), y: coord_t'(dy), z: coord_t'(dz)};
    r.pixel_h = 11'($urandom);
    r.pixel_v = 10'($urandom);
    return r;
  endfunction

  function automatic sphere_t make_sphere(input int x, input int y, input int z, input int rad,
                                          input int r, input int g, input int b);
    sphere_t s;
    s.center = '{x: coord_t'(x), y: coord_t'(y), z: coord_t'(z)};
    s.radius = 8'(rad);
    s.color = '{r: 8'(r), g: 8'(g), b: 8'(b)};
    return s;
  endfunction

  // scene may only change with the pipeline empty
  task automatic drain();
    do @(posedge clk); while (checker0.pending() != 0);
  endtask

  initial begin
    int k;
    int ox, oy, oz, dv;
    void'($urandom(32'hf056f6af));
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // register read-back including unused addresses
    load_sphere(0, make_sphere(-100, 50, 200, 30, 255, 0, 0));
    load_sphere(1, make_sphere(20, -300, 511, 255, 1, 2, 3));
    load_sphere(2, make_sphere(-512, 0, -1, 7, 10, 200, 90));
    set_count(3);
    for (int i = 0; i < 3; i++) begin
      for (int w = 0; w < 3; w++) axi_read(8'(i * OBJ_STRIDE + 4 * w), sphere_word(sc[i], w));
    end
    axi_read(COUNT_ADDR, 32'd3);
    axi_read(8'h0c, 32'd0);
    axi_read(8'h90, 32'd0);
    drain();

    // empty scene gives background everywhere
    set_count(0);
    for (int i = 0; i < 5; i++) send_ray(make_ray(0, 0, 0, i, 1, 3));
    drain();

    // one sphere with rays at it, beside it and behind it
    load_sphere(0, make_sphere(0, 0, 100, 20, 200, 100, 50));
    set_count(1);
    send_ray(make_ray(0, 0, 0, 0, 0, 1));
    send_ray(make_ray(60, 0, 0, 0, 0, 1));
    send_ray(make_ray(0, 0, 200, 0, 0, 1));
    send_ray(make_ray(0, 0, 200, 0, 0, -1));
    send_ray(make_ray(0, 0, 0, 1, 0, 5));
    drain();

    // overlapping depths, an exact tie, and far hits
    load_sphere(0, make_sphere(0, 0, 300, 30, 10, 20, 30));
    load_sphere(1, make_sphere(0, 0, 150, 30, 100, 110, 120));
    load_sphere(2, make_sphere(0, 0, 150, 30, 7, 8, 9));
    load_sphere(3, make_sphere(100, 0, 120, 25, 255, 129, 3));
    set_count(4);
    send_ray(make_ray(0, 0, 0, 0, 0, 1));
    send_ray(make_ray(0, 0, 0, 0, 0, 40));
    send_ray(make_ray(100, 0, 0, 0, 0, 1));
    send_ray(make_ray(100, 0, 0, 0, 0, 50));
    send_ray(make_ray(0, 0, 200, 0, 0, 1));
    drain();

    // random full scene with random back-pressure
    for (int i = 0; i < SCENE_DEPTH; i++) begin
      load_sphere(i, make_sphere(rand_range(-150, 150), rand_range(-150, 150),
                                 rand_range(100, 400), rand_range(10, 60),
                                 rand_range(0, 255), rand_range(0, 255), rand_range(0, 255)));
    end
    set_count(SCENE_DEPTH);
    bp_on <= 1'b1;
    for (int i = 0; i < 300; i++) begin
      k = rand_range(0, SCENE_DEPTH - 1);
      ox = rand_range(-30, 30);
      oy = rand_range(-30, 30);
      oz = rand_range(-30, 30);
      dv = rand_range(1, 8);
      // aim roughly at one sphere so hits and misses both show up
      send_ray(make_ray(ox, oy, oz,
                        (int'(sc[k].center.x) - ox) / dv + rand_range(-3, 3),
                        (int'(sc[k].center.y) - oy) / dv + rand_range(-3, 3),
                        (int'(sc[k].center.z) - oz) / dv + rand_range(-3, 3)));
    end
    drain();
    bp_on <= 1'b0;

    checker0.end_check();
    $display("pixel checks %0d, read checks %0d, errors %0d",
             checker0.pix_checks, checker0.rd_checks, checker0.errors);
    if (checker0.errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== rt_checker.sv ====
`timescale 1ns/1ns

module rt_checker (
  input wire                  clk,
  input wire                  rst_n,
  // pixel stream as seen at the dut output
  input wire                  pix_valid,
  input wire                  pix_ready,
  input wire rt_pkg::pixel_t  pix,
  // axi responses
  input wire                  bvalid,
  input wire                  bready,
  input wire [1:0]            bresp,
  input wire                  rvalid,
  input wire                  rready,
  input wire [31:0]           rdata,
  input wire [1:0]            rresp
);
  import rt_pkg::*;

  pixel_t      exp_pix [$];
  logic [31:0] exp_rd [$];
  int errors = 0;
  int pix_checks = 0;
  int rd_checks = 0;

  // expectations are queued by the stimulus side
  task automatic expect_pixel(input pixel_t p);
    exp_pix.push_back(p);
  endtask

  task automatic expect_read(input logic [31:0] w);
    exp_rd.push_back(w);
  endtask

  function automatic int pending();
    return exp_pix.size() + exp_rd.size();
  endfunction

  always @(posedge clk) begin
    pixel_t want;
    logic [31:0] want_rd;
    if (rst_n && pix_valid && pix_ready) begin
      if (exp_pix.size() == 0) begin
        $display("a pixel came out with no ray waiting for it at time %0t", $time);
        errors++;
      end else begin
        want = exp_pix.pop_front();
        pix_checks++;
        if (pix !== want) begin
          $display("** Error @%0t: pixel got rgb %h at (%0d,%0d), exp rgb %h at (%0d,%0d)",
                   $time, pix.color, pix.pixel_h, pix.pixel_v,
                   want.color, want.pixel_h, want.pixel_v);
          errors++;
        end
      end
    end
    if (rst_n && bvalid && bready && bresp !== AXI_RESP_OKAY) begin
      $display("** Error @%0t: write response %0d, exp okay", $time, bresp);
      errors++;
    end
    if (rst_n && rvalid && rready) begin
      if (exp_rd.size() == 0) begin
        $display("a read response came with no read pending at time %0t", $time);
        errors++;
      end else begin
        want_rd = exp_rd.pop_front();
        rd_checks++;
        if (rdata !== want_rd || rresp !== AXI_RESP_OKAY) begin
          $display("** Error @%0t: read got %h resp %0d, exp %h okay",
                   $time, rdata, rresp, want_rd);
          errors++;
        end
      end
    end
  end

  // anything still queued at the end never arrived
  task automatic end_check();
    if (exp_pix.size() != 0) begin
      $display("%0d expected pixels never arrived", exp_pix.size());
      errors++;
    end
    if (exp_rd.size() != 0) begin
      $display("%0d expected read responses never arrived", exp_rd.size());
      errors++;
    end
  endtask

endmodule

// ==== ray_tracer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ray_tracer (
  input  wire                            clk,
  input  wire                            rst_n,
  // axi4-lite scene port
  input  wire  [rt_pkg::AXI_ADDR_W-1:0]  awaddr,
  input  wire                            awvalid,
  output logic                           awready,
  input  wire  [rt_pkg::AXI_DATA_W-1:0]  wdata,
  input  wire                            wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  wire                            bready,
  input  wire  [rt_pkg::AXI_ADDR_W-1:0]  araddr,
  input  wire                            arvalid,
  output logic                           arready,
  output logic [rt_pkg::AXI_DATA_W-1:0]  rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  wire                            rready,
  // ray stream in
  input  wire                            ray_valid,
  output logic                           ray_ready,
  input  wire  rt_pkg::ray_req_t         ray,
  // pixel stream out
  output logic                           pix_valid,
  input  wire                            pix_ready,
  output rt_pkg::pixel_t                 pix
);
  import rt_pkg::*;

  // input stage to intersector
  logic     rq_valid;
  logic     rq_ready;
  ray_req_t rq;

  // intersector to shader
  logic hit_valid;
  logic hit_ready;
  hit_t hit;

  // shader to output stage
  logic   sh_valid;
  logic   sh_ready;
  pixel_t sh_pix;

  // scene lookup
  logic [OBJ_IDX_W-1:0] obj_idx;
  sphere_t              obj;
  logic                 obj_valid;
  logic                 obj_last;

  stage_reg #(.payload_t(ray_req_t)) ray_in_stage (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(ray_valid),
    .in_ready(ray_ready),
    .in_data(ray),
    .out_valid(rq_valid),
    .out_ready(rq_ready),
    .out_data(rq)
  );

  ray_intersector ray_intx (
    .clk(clk),
    .rst_n(rst_n),
    .ray_valid(rq_valid),
    .ray_ready(rq_ready),
    .ray(rq),
    .obj_idx(obj_idx),
    .obj(obj),
    .obj_valid(obj_valid),
    .obj_last(obj_last),
    .hit_valid(hit_valid),
    .hit_ready(hit_ready),
    .hit(hit)
  );

  ray_shader shader (
    .clk(clk),
    .rst_n(rst_n),
    .hit_valid(hit_valid),
    .hit_ready(hit_ready),
    .hit(hit),
    .pix_valid(sh_valid),
    .pix_ready(sh_ready),
    .pix(sh_pix)
  );

  // pixel output slice
  stage_reg #(.payload_t(pixel_t)) pix_out_stage (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(sh_valid),
    .in_ready(sh_ready),
    .in_data(sh_pix),
    .out_valid(pix_valid),
    .out_ready(pix_ready),
    .out_data(pix)
  );

  scene_buffer scene (
    .clk(clk),
    .rst_n(rst_n),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .obj_idx(obj_idx),
    .obj(obj),
    .obj_valid(obj_valid),
    .obj_last(obj_last)
  );

endmodule

`default_nettype wire

// ==== ray_shader.sv ====
`timescale 1ns/1ns
`default_nettype none

module ray_shader (
  input  wire               clk,
  input  wire               rst_n,
  // hit in
  input  wire               hit_valid,
  output logic              hit_ready,
  input  wire  rt_pkg::hit_t hit,
  // shaded pixel out
  output logic              pix_valid,
  input  wire               pix_ready,
  output rt_pkg::pixel_t    pix
);
  import rt_pkg::*;

  pixel_t shaded;

  // same one entry handshake as a register slice
  assign hit_ready = !pix_valid || pix_ready;

  always_comb begin
    shaded.pixel_h = hit.pixel_h;
    shaded.pixel_v = hit.pixel_v;
    if (!hit.hit_any) begin
      shaded.color = BG_COLOR;
    end else if (hit.hit_dot < FAR_DOT) begin
      shaded.color = hit.hit_color;
    end else begin
      // far hit, half brightness, rounded down
      shaded.color.r = {1'b0, hit.hit_color.r[7:1]};
      shaded.color.g = {1'b0, hit.hit_color.g[7:1]};
      shaded.color.b = {1'b0, hit.hit_color.b[7:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
    end else if (hit_ready) begin
      pix_valid <= hit_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_valid && hit_ready) begin
      pix <= shaded;
    end
  end

endmodule

`default_nettype wire

// ==== ray_intersector.sv ====
`timescale 1ns/1ns
`default_nettype none

module ray_intersector (
  input  wire                           clk,
  input  wire                           rst_n,
  // ray in
  input  wire                           ray_valid,
  output logic                          ray_ready,
  input  wire  rt_pkg::ray_req_t        ray,
  // scene read port
  output logic [rt_pkg::OBJ_IDX_W-1:0]  obj_idx,
  input  wire  rt_pkg::sphere_t         obj,
  input  wire                           obj_valid,
  input  wire                           obj_last,
  // nearest hit out
  output logic                          hit_valid,
  input  wire                           hit_ready,
  output rt_pkg::hit_t                  hit
);
  import rt_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_DONE
  } state_t;

  state_t state;
  ray_req_t ray_q;
  logic [OBJ_IDX_W-1:0] idx;

  // best hit so far
  logic best_any;
  rgb_t best_color;
  dot_t best_dot;

  // center minus origin needs one extra bit
  logic signed [10:0] oc_x;
  logic signed [10:0] oc_y;
  logic signed [10:0] oc_z;
  dot_t dot_oc_d;
  dot_t oc_sq;
  dot_t d_sq;
  logic signed [8:0] rad_s;
  // discriminant terms reach about 42 bits
  logic signed [47:0] disc_lhs;
  logic signed [47:0] disc_rhs;

  logic hit_now;
  logic closer;
  logic upd;
  logic take_ray;
  logic take_hit;
  logic scan_end;

  assign hit_valid = (state == ST_DONE);
  assign take_hit  = hit_valid && hit_ready;
  // a new ray may enter in the same cycle the old hit leaves
  assign ray_ready = (state == ST_IDLE) || take_hit;
  assign take_ray  = ray_valid && ray_ready;

  // stop on the last object, or right away for an empty scene
  assign scan_end = (state == ST_SCAN) && (obj_last || !obj_valid);
  assign obj_idx  = idx;

  // hit test of the current object against the latched ray
  always_comb begin
    oc_x = $signed(obj.center.x) - $signed(ray_q.origin.x);
    oc_y = $signed(obj.center.y) - $signed(ray_q.origin.y);
    oc_z = $signed(obj.center.z) - $signed(ray_q.origin.z);

    dot_oc_d = oc_x * $signed(ray_q.dir.x) + oc_y * $signed(ray_q.dir.y)
             + oc_z * $signed(ray_q.dir.z);
    oc_sq = oc_x * oc_x + oc_y * oc_y + oc_z * oc_z;
    d_sq  = $signed(ray_q.dir.x) * $signed(ray_q.dir.x)
          + $signed(ray_q.dir.y) * $signed(ray_q.dir.y)
          + $signed(ray_q.dir.z) * $signed(ray_q.dir.z);

    // squared distance from center to the ray line, scaled by d.d
    rad_s    = $signed({1'b0, obj.radius});
    disc_lhs = oc_sq * d_sq - dot_oc_d * dot_oc_d;
    disc_rhs = rad_s * rad_s * d_sq;

    // sphere must lie in front of the origin
    hit_now = obj_valid && (dot_oc_d > 0) && (disc_lhs <= disc_rhs);
    // strict compare keeps the lower index on a tie
    closer  = !best_any || (dot_oc_d < best_dot);
  end

  assign upd = (state == ST_SCAN) && hit_now && closer;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      idx      <= '0;
      best_any <= 1'b0;
    end else begin
      if (take_ray) begin
        // fresh record for the new ray
        state    <= ST_SCAN;
        idx      <= '0;
        best_any <= 1'b0;
      end else if (state == ST_SCAN) begin
        if (upd) begin
          best_any <= 1'b1;
        end
        if (scan_end) begin
          state <= ST_DONE;
        end else begin
          idx <= idx + 1'b1;
        end
      end else if (take_hit) begin
        state <= ST_IDLE;
      end
    end
  end

  // ray and best hit payload
  always_ff @(posedge clk) begin
    if (take_ray) begin
      ray_q <= ray;
    end
    if (upd) begin
      best_color <= obj.color;
      best_dot   <= dot_oc_d;
    end
  end

  // color and dot are don't care while hit_any is low
  always_comb begin
    hit.hit_any   = best_any;
    hit.hit_color = best_color;
    hit.hit_dot   = best_dot;
    hit.pixel_h   = ray_q.pixel_h;
    hit.pixel_v   = ray_q.pixel_v;
  end

endmodule

`default_nettype wire

// ==== scene_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module scene_buffer (
  input  wire                            clk,
  input  wire                            rst_n,
  // axi4-lite write address, data and response
  input  wire  [rt_pkg::AXI_ADDR_W-1:0]  awaddr,
  input  wire                            awvalid,
  output logic                           awready,
  input  wire  [rt_pkg::AXI_DATA_W-1:0]  wdata,
  input  wire                            wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  wire                            bready,
  // axi4-lite read address and data
  input  wire  [rt_pkg::AXI_ADDR_W-1:0]  araddr,
  input  wire                            arvalid,
  output logic                           arready,
  output logic [rt_pkg::AXI_DATA_W-1:0]  rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  wire                            rready,
  // indexed object port for the intersector
  input  wire  [rt_pkg::OBJ_IDX_W-1:0]   obj_idx,
  output rt_pkg::sphere_t                obj,
  output logic                           obj_valid,
  output logic                           obj_last
);
  import rt_pkg::*;

  sphere_t spheres [SCENE_DEPTH];
  logic [CNT_W-1:0] count;

  logic wr_go;
  logic rd_go;
  logic wr_in_table;
  logic rd_in_table;
  logic [OBJ_IDX_W-1:0] wr_obj;
  logic [OBJ_IDX_W-1:0] rd_obj_idx;
  sphere_t rd_obj;
  logic [AXI_DATA_W-1:0] rd_word;

  // aw and w are taken together, only with no response outstanding
  assign wr_go   = awvalid && wvalid && !bvalid;
  assign awready = wr_go;
  assign wready  = wr_go;

  // one read in flight at a time
  assign arready = !rvalid;
  assign rd_go   = arvalid && arready;

  // every access answers okay, even unmapped ones
  assign bresp = AXI_RESP_OKAY;
  assign rresp = AXI_RESP_OKAY;

  // slot number and table range check
  assign wr_in_table = awaddr < (SCENE_DEPTH * OBJ_STRIDE);
  assign rd_in_table = araddr < (SCENE_DEPTH * OBJ_STRIDE);
  assign wr_obj      = OBJ_IDX_W'(awaddr / OBJ_STRIDE);
  assign rd_obj_idx  = OBJ_IDX_W'(araddr / OBJ_STRIDE);

  // control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count  <= '0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_go && awaddr == COUNT_ADDR) begin
        // saturate at table depth
        if (wdata > SCENE_DEPTH) begin
          count <= CNT_W'(SCENE_DEPTH);
        end else begin
          count <= CNT_W'(wdata);
        end
      end
      // b goes out the cycle after the write is taken
      if (wr_go) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_go) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // sphere table fields, word offset picks the field group
  always_ff @(posedge clk) begin
    if (wr_go && wr_in_table) begin
      case (awaddr[3:2])
        2'd0: begin
          spheres[wr_obj].center.x <= wdata[9:0];
          spheres[wr_obj].center.y <= wdata[25:16];
        end
        2'd1: begin
          spheres[wr_obj].center.z <= wdata[9:0];
          spheres[wr_obj].radius   <= wdata[23:16];
        end
        2'd2: begin
          spheres[wr_obj].color.r <= wdata[7:0];
          spheres[wr_obj].color.g <= wdata[15:8];
          spheres[wr_obj].color.b <= wdata[23:16];
        end
        default: begin
        end
      endcase
    end
  end

  // read-back mux
  // coordinates come back zero padded, as raw 10 bit fields
  always_comb begin
    rd_obj  = spheres[rd_obj_idx];
    rd_word = '0;
    if (rd_in_table) begin
      case (araddr[3:2])
        2'd0:    rd_word = {6'd0, rd_obj.center.y, 6'd0, rd_obj.center.x};
        2'd1:    rd_word = {8'd0, rd_obj.radius, 6'd0, rd_obj.center.z};
        2'd2:    rd_word = {8'd0, rd_obj.color.b, rd_obj.color.g, rd_obj.color.r};
        default: rd_word = '0;
      endcase
    end else if (araddr == COUNT_ADDR) begin
      rd_word = AXI_DATA_W'(count);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      rdata <= rd_word;
    end
  end

  // intersector port, all combinational
  assign obj       = spheres[obj_idx];
  assign obj_valid = CNT_W'(obj_idx) < count;
  // compare idx+1 so an empty scene never flags last
  assign obj_last  = (CNT_W'(obj_idx) + 1'b1) == count;

endmodule

`default_nettype wire

// ==== stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
  parameter type payload_t = rt_pkg::pixel_t
) (
  input  wire            clk,
  input  wire            rst_n,
  // upstream side
  input  wire            in_valid,
  output logic           in_ready,
  input  wire  payload_t in_data,
  // downstream side
  output logic           out_valid,
  input  wire            out_ready,
  output payload_t       out_data
);

  // one entry slice
  // takes a new item when empty or when the held one leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      // refill or drain
      out_valid <= in_valid;
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== rt_pkg.sv ====
package rt_pkg;

  // scene size and object index width
  localparam int SCENE_DEPTH = 8;
  localparam int OBJ_IDX_W   = 3;
  // object count register holds 0..SCENE_DEPTH
  localparam int CNT_W       = 4;

  // hits at or beyond this dot product get dimmed
  localparam int FAR_DOT = 4096;

  // axi4-lite geometry of the scene buffer
  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // address map
  // each sphere takes a 16 byte slot, words 0..2 used
  localparam int OBJ_STRIDE = 16;
  localparam logic [AXI_ADDR_W-1:0] COUNT_ADDR = 8'h80;

  // integer world coordinates keep all products exact
  typedef logic signed [9:0] coord_t;

  // wide enough for any dot product of offsets and directions
  typedef logic signed [23:0] dot_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // color for rays that miss everything
  localparam rgb_t BG_COLOR = '{r: 8'd16, g: 8'd32, b: 8'd64};

  typedef struct packed {
    vec3_t      center;
    logic [7:0] radius;
    rgb_t       color;
  } sphere_t;

  typedef struct packed {
    vec3_t       origin;
    vec3_t       dir;
    logic [10:0] pixel_h;
    logic [9:0]  pixel_v;
  } ray_req_t;

  // nearest hit as seen by the intersector
  typedef struct packed {
    logic        hit_any;
    rgb_t        hit_color;
    dot_t        hit_dot;
    logic [10:0] pixel_h;
    logic [9:0]  pixel_v;
  } hit_t;

  typedef struct packed {
    rgb_t        color;
    logic [10:0] pixel_h;
    logic [9:0]  pixel_v;
  } pixel_t;

endpackage
